// File: common/chrono_pkg.sv
//////////////////////////////////////////////////
// Chrono bus shared definitions.
// Bus widths, address map, register indices and
// the access kinds passed from decode to execute.
//////////////////////////////////////////////////

`default_nettype none

package chrono_pkg;

  // Host side of the AVR-style external memory bus.
  localparam int MPU_ADDR_WIDTH = 16;
  localparam int MPU_AD_WIDTH   = 8;
  localparam int MPU_AH_WIDTH   = 8;

  // Internal word bus.
  localparam int WORD_WIDTH      = 16;
  localparam int WORD_ADDR_WIDTH = 15;

  // External SRAM and bank select.
  localparam int VRAM_ADDR_WIDTH = 16;
  localparam int BANK_WIDTH      = 2;

  // Word address 4000h is byte address 8000h.
  localparam logic [WORD_ADDR_WIDTH-1:0] VRAM_WINDOW_BASE = 15'h4000;

  localparam logic [WORD_WIDTH-1:0] CHIP_ID = 16'h4343;

  // Register map, by word address.
  typedef enum logic [WORD_ADDR_WIDTH-1:0] {
    REG_ID        = 15'd0,
    REG_SCRATCH   = 15'd1,
    REG_VRAM_BANK = 15'd2
  } reg_index_t;

  // One-cycle command issued by the decoder.
  typedef enum logic [2:0] {
    ACC_NONE,
    ACC_REG_READ,
    ACC_REG_WRITE,
    ACC_VRAM_READ,
    ACC_VRAM_WRITE
  } access_t;

endpackage

`default_nettype wire

// File: avr_bus/avr_bus_adapter.sv
//////////////////////////////////////////////////
// AVR bus adapter.
// Captures the low address from the muxed A/D bus,
// forms a word address with byte enables, and
// steers read bytes back onto the A/D bus.
//////////////////////////////////////////////////

`default_nettype none

module avr_bus_adapter (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    mpu_rd_n,
  input  logic                                    mpu_wr_n,
  input  logic                                    mpu_ale,
  input  logic [chrono_pkg::MPU_AH_WIDTH-1:0]     mpu_ah,
  input  logic [chrono_pkg::WORD_WIDTH-1:0]       rdata,
  inout  wire  [chrono_pkg::MPU_AD_WIDTH-1:0]     mpu_ad,
  output logic [chrono_pkg::WORD_ADDR_WIDTH-1:0]  word_addr,
  output logic [1:0]                              be_n,
  output logic [chrono_pkg::WORD_WIDTH-1:0]       wdata,
  output logic                                    rd_n,
  output logic                                    wr_n
);

  // Low address byte, held after ALE drops.
  logic [chrono_pkg::MPU_AD_WIDTH-1:0]   addr_low;
  // Full host byte address.
  logic [chrono_pkg::MPU_ADDR_WIDTH-1:0] byte_addr;
  logic [chrono_pkg::MPU_AD_WIDTH-1:0]   rdata_byte;
  logic                                  drive_ad;

  // Clocked stand-in for the address latch.
  always_ff @(posedge clk) begin
    if (reset) begin
      addr_low <= '0;
    end else if (mpu_ale) begin
      addr_low <= mpu_ad;
    end
  end

  assign byte_addr = {mpu_ah, addr_low};

  // Drop the byte bit to get the word address.
  assign word_addr = byte_addr[chrono_pkg::MPU_ADDR_WIDTH-1:1];

  // Odd address enables the high byte, even the low byte.
  assign be_n = byte_addr[0] ? 2'b01 : 2'b10;

  // Incoming byte goes to both lanes; be_n picks the one that counts.
  assign wdata = {mpu_ad, mpu_ad};

  assign rd_n = mpu_rd_n;
  assign wr_n = mpu_wr_n;

  // Pick the byte lane addressed by the host.
  assign rdata_byte = byte_addr[0] ? rdata[15:8] : rdata[7:0];

  // Only drive during a clean read with the address phase over.
  assign drive_ad = ~mpu_rd_n & mpu_wr_n & ~mpu_ale;
  assign mpu_ad   = drive_ad ? rdata_byte : 'z;

endmodule

`default_nettype wire

// File: source/mpu_decode.sv
//////////////////////////////////////////////////
// Host access decoder.
// Finds strobe falls and issues a one-cycle
// command for register or VRAM space.
//////////////////////////////////////////////////

`default_nettype none

module mpu_decode (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic [chrono_pkg::WORD_ADDR_WIDTH-1:0]  word_addr,
  input  logic [1:0]                              be_n,
  input  logic [chrono_pkg::WORD_WIDTH-1:0]       wdata,
  input  logic                                    rd_n,
  input  logic                                    wr_n,
  output chrono_pkg::access_t                     cmd,
  output logic [chrono_pkg::WORD_ADDR_WIDTH-1:0]  cmd_addr,
  output logic [1:0]                              cmd_be_n,
  output logic [chrono_pkg::WORD_WIDTH-1:0]       cmd_wdata
);

  // Strobes from the previous cycle.
  logic                rd_q;
  logic                wr_q;
  logic                rd_fall;
  logic                wr_fall;
  logic                in_window;
  chrono_pkg::access_t next_cmd;

  assign rd_fall   = rd_q & ~rd_n;
  assign wr_fall   = wr_q & ~wr_n;
  assign in_window = (word_addr >= chrono_pkg::VRAM_WINDOW_BASE);

  // Classify the access. Both strobes low is illegal and ignored.
  always_comb begin
    next_cmd = chrono_pkg::ACC_NONE;
    if (rd_n | wr_n) begin
      if (rd_fall) begin
        next_cmd = in_window ? chrono_pkg::ACC_VRAM_READ : chrono_pkg::ACC_REG_READ;
      end else if (wr_fall) begin
        next_cmd = in_window ? chrono_pkg::ACC_VRAM_WRITE : chrono_pkg::ACC_REG_WRITE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_q <= 1'b1;
      wr_q <= 1'b1;
      cmd  <= chrono_pkg::ACC_NONE;
    end else begin
      rd_q <= rd_n;
      wr_q <= wr_n;
      cmd  <= next_cmd;
    end
  end

  // Command payload, captured alongside the command.
  always_ff @(posedge clk) begin
    if (rd_fall | wr_fall) begin
      cmd_addr  <= word_addr;
      cmd_be_n  <= be_n;
      cmd_wdata <= wdata;
    end
  end

  // The host never asserts read and write at once.
  assert property (@(posedge clk) disable iff (reset) rd_n | wr_n)
    else $error("Read and write strobes both low");

endmodule

`default_nettype wire

// File: source/ctrl_registers.sv
//////////////////////////////////////////////////
// Control registers.
// ID, scratch and VRAM bank with byte-enabled
// writes and one-cycle read response.
//////////////////////////////////////////////////

`default_nettype none

module ctrl_registers (
  input  logic                                    clk,
  input  logic                                    reset,
  input  chrono_pkg::access_t                     cmd,
  input  logic [chrono_pkg::WORD_ADDR_WIDTH-1:0]  cmd_addr,
  input  logic [1:0]                              cmd_be_n,
  input  logic [chrono_pkg::WORD_WIDTH-1:0]       cmd_wdata,
  output logic [chrono_pkg::WORD_WIDTH-1:0]       reg_rdata,
  output logic                                    reg_rvalid,
  output logic [chrono_pkg::BANK_WIDTH-1:0]       vram_bank
);

  logic [chrono_pkg::WORD_WIDTH-1:0] scratch;
  logic [chrono_pkg::WORD_WIDTH-1:0] read_value;
  chrono_pkg::reg_index_t            index;

  assign index = chrono_pkg::reg_index_t'(cmd_addr);

  // Readback mux. Unmapped addresses read as zero.
  always_comb begin
    case (index)
      chrono_pkg::REG_ID:        read_value = chrono_pkg::CHIP_ID;
      chrono_pkg::REG_SCRATCH:   read_value = scratch;
      chrono_pkg::REG_VRAM_BANK: read_value = {{(chrono_pkg::WORD_WIDTH -
                                                 chrono_pkg::BANK_WIDTH){1'b0}}, vram_bank};
      default:                   read_value = '0;
    endcase
  end

  ////////////////////////////////////////////////
  // Writes, per byte lane.
  ////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      scratch   <= '0;
      vram_bank <= '0;
    end else if (cmd == chrono_pkg::ACC_REG_WRITE) begin
      if (index == chrono_pkg::REG_SCRATCH) begin
        if (!cmd_be_n[0]) scratch[7:0]  <= cmd_wdata[7:0];
        if (!cmd_be_n[1]) scratch[15:8] <= cmd_wdata[15:8];
      end
      // Bank lives in the low byte only.
      if (index == chrono_pkg::REG_VRAM_BANK && !cmd_be_n[0]) begin
        vram_bank <= cmd_wdata[chrono_pkg::BANK_WIDTH-1:0];
      end
    end
  end

  // Read response, one cycle after the command.
  always_ff @(posedge clk) begin
    if (reset) begin
      reg_rvalid <= 1'b0;
    end else begin
      reg_rvalid <= (cmd == chrono_pkg::ACC_REG_READ);
    end
  end

  always_ff @(posedge clk) begin
    if (cmd == chrono_pkg::ACC_REG_READ) begin
      reg_rdata <= read_value;
    end
  end

endmodule

`default_nettype wire

// File: vram/vram_controller.sv
//////////////////////////////////////////////////
// VRAM controller.
// Runs two-cycle SRAM read and write cycles on
// the external VRAM pins, one command at a time.
//////////////////////////////////////////////////

`default_nettype none

module vram_controller (
  input  logic                                    clk,
  input  logic                                    reset,
  input  chrono_pkg::access_t                     cmd,
  input  logic [chrono_pkg::WORD_ADDR_WIDTH-2:0]  cmd_addr,
  input  logic [1:0]                              cmd_be_n,
  input  logic [chrono_pkg::WORD_WIDTH-1:0]       cmd_wdata,
  input  logic [chrono_pkg::BANK_WIDTH-1:0]       vram_bank,
  output logic [chrono_pkg::WORD_WIDTH-1:0]       vram_rdata,
  output logic                                    vram_rvalid,
  output logic                                    vram_en_n,
  output logic                                    vram_rd_n,
  output logic                                    vram_wr_n,
  output logic [1:0]                              vram_be_n,
  output logic [chrono_pkg::VRAM_ADDR_WIDTH-1:0]  vram_addr,
  inout  wire  [chrono_pkg::WORD_WIDTH-1:0]       vram_data
);

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    LAST,
    DONE
  } state_t;

  state_t                            state;
  logic                              start;
  logic                              is_read;
  logic                              op_read;
  logic                              drive_data;
  logic [chrono_pkg::WORD_WIDTH-1:0] wdata_q;

  assign is_read = (cmd == chrono_pkg::ACC_VRAM_READ);
  assign start   = is_read || (cmd == chrono_pkg::ACC_VRAM_WRITE);

  // Data pins only driven during a write cycle.
  assign vram_data = drive_data ? wdata_q : 'z;

  ////////////////////////////////////////////////
  // Cycle sequencer.
  ////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= IDLE;
      vram_en_n   <= 1'b1;
      vram_rd_n   <= 1'b1;
      vram_wr_n   <= 1'b1;
      vram_be_n   <= 2'b11;
      vram_rvalid <= 1'b0;
      drive_data  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state      <= ACCESS;
            vram_en_n  <= 1'b0;
            vram_rd_n  <= ~is_read;
            vram_wr_n  <= is_read;
            vram_be_n  <= cmd_be_n;
            drive_data <= ~is_read;
          end
        end
        // Strobes stay low through LAST.
        ACCESS: state <= LAST;
        LAST: begin
          state       <= DONE;
          vram_en_n   <= 1'b1;
          vram_rd_n   <= 1'b1;
          vram_wr_n   <= 1'b1;
          vram_be_n   <= 2'b11;
          drive_data  <= 1'b0;
          vram_rvalid <= op_read;
        end
        DONE: begin
          state       <= IDLE;
          vram_rvalid <= 1'b0;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Address, write data and direction held for the whole cycle.
  always_ff @(posedge clk) begin
    if (state == IDLE && start) begin
      vram_addr <= {vram_bank, cmd_addr};
      wdata_q   <= cmd_wdata;
      op_read   <= is_read;
    end
  end

  // Read data sampled at the end of LAST.
  always_ff @(posedge clk) begin
    if (state == LAST && op_read) begin
      vram_rdata <= vram_data;
    end
  end

  // Host strobe width keeps commands from overlapping a cycle.
  assert property (@(posedge clk) disable iff (reset) (state != IDLE) |-> !start)
    else $error("VRAM command while controller busy");

  // Strobes never overlap, and both are released outside ACCESS and LAST.
  assert property (@(posedge clk) disable iff (reset)
                   (vram_rd_n | vram_wr_n) &&
                   (state == ACCESS || state == LAST || (vram_rd_n && vram_wr_n)))
    else $error("VRAM strobes overlap or are low outside an access");

endmodule

`default_nettype wire

// File: source/read_return.sv
//////////////////////////////////////////////////
// Read return holding register.
// Keeps the last read word from either source
// for the adapter to present.
//////////////////////////////////////////////////

`default_nettype none

module read_return (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [chrono_pkg::WORD_WIDTH-1:0] reg_rdata,
  input  logic                              reg_rvalid,
  input  logic [chrono_pkg::WORD_WIDTH-1:0] vram_rdata,
  input  logic                              vram_rvalid,
  output logic [chrono_pkg::WORD_WIDTH-1:0] rdata
);

  // Load from whichever source answered, else hold.
  always_ff @(posedge clk) begin
    if (reset) begin
      rdata <= '0;
    end else if (reg_rvalid) begin
      rdata <= reg_rdata;
    end else if (vram_rvalid) begin
      rdata <= vram_rdata;
    end
  end

  // Only one command is in flight, so only one source answers.
  assert property (@(posedge clk) disable iff (reset) !(reg_rvalid && vram_rvalid))
    else $error("Register and VRAM read data valid together");

endmodule

`default_nettype wire

// File: source/chrono_bus_top.sv
//////////////////////////////////////////////////
// Chrono bus top level.
// Host bus adapter, decoder, registers, VRAM
// controller and read return, wired together.
//////////////////////////////////////////////////

`default_nettype none

module chrono_bus_top (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    mpu_rd_n,
  input  logic                                    mpu_wr_n,
  input  logic                                    mpu_ale,
  input  logic [chrono_pkg::MPU_AH_WIDTH-1:0]     mpu_ah,
  inout  wire  [chrono_pkg::MPU_AD_WIDTH-1:0]     mpu_ad,
  output logic                                    vram_en_n,
  output logic                                    vram_rd_n,
  output logic                                    vram_wr_n,
  output logic [1:0]                              vram_be_n,
  output logic [chrono_pkg::VRAM_ADDR_WIDTH-1:0]  vram_addr,
  inout  wire  [chrono_pkg::WORD_WIDTH-1:0]       vram_data
);

  // Adapter to decode.
  logic [chrono_pkg::WORD_ADDR_WIDTH-1:0] word_addr;
  logic [1:0]                             be_n;
  logic [chrono_pkg::WORD_WIDTH-1:0]      wdata;
  logic                                   rd_n;
  logic                                   wr_n;

  // Decode to execute.
  chrono_pkg::access_t                    cmd;
  logic [chrono_pkg::WORD_ADDR_WIDTH-1:0] cmd_addr;
  logic [1:0]                             cmd_be_n;
  logic [chrono_pkg::WORD_WIDTH-1:0]      cmd_wdata;
  logic [chrono_pkg::BANK_WIDTH-1:0]      vram_bank;

  // Execute to result, and result back to the adapter.
  logic [chrono_pkg::WORD_WIDTH-1:0]      reg_rdata;
  logic                                   reg_rvalid;
  logic [chrono_pkg::WORD_WIDTH-1:0]      vram_rdata;
  logic                                   vram_rvalid;
  logic [chrono_pkg::WORD_WIDTH-1:0]      rdata;

  avr_bus_adapter adapter0 (
    .clk(clk), .reset(reset),
    .mpu_rd_n(mpu_rd_n), .mpu_wr_n(mpu_wr_n), .mpu_ale(mpu_ale),
    .mpu_ah(mpu_ah), .rdata(rdata), .mpu_ad(mpu_ad),
    .word_addr(word_addr), .be_n(be_n), .wdata(wdata), .rd_n(rd_n), .wr_n(wr_n)
  );

  mpu_decode decode0 (
    .clk(clk), .reset(reset),
    .word_addr(word_addr), .be_n(be_n), .wdata(wdata), .rd_n(rd_n), .wr_n(wr_n),
    .cmd(cmd), .cmd_addr(cmd_addr), .cmd_be_n(cmd_be_n), .cmd_wdata(cmd_wdata)
  );

  ctrl_registers regs0 (
    .clk(clk), .reset(reset),
    .cmd(cmd), .cmd_addr(cmd_addr), .cmd_be_n(cmd_be_n), .cmd_wdata(cmd_wdata),
    .reg_rdata(reg_rdata), .reg_rvalid(reg_rvalid), .vram_bank(vram_bank)
  );

  // Window offset is the word address below the window bit.
  vram_controller vram0 (
    .clk(clk), .reset(reset),
    .cmd(cmd), .cmd_addr(cmd_addr[chrono_pkg::WORD_ADDR_WIDTH-2:0]),
    .cmd_be_n(cmd_be_n), .cmd_wdata(cmd_wdata), .vram_bank(vram_bank),
    .vram_rdata(vram_rdata), .vram_rvalid(vram_rvalid),
    .vram_en_n(vram_en_n), .vram_rd_n(vram_rd_n), .vram_wr_n(vram_wr_n),
    .vram_be_n(vram_be_n), .vram_addr(vram_addr), .vram_data(vram_data)
  );

  read_return return0 (
    .clk(clk), .reset(reset),
    .reg_rdata(reg_rdata), .reg_rvalid(reg_rvalid),
    .vram_rdata(vram_rdata), .vram_rvalid(vram_rvalid),
    .rdata(rdata)
  );

endmodule

`default_nettype wire

// File: tests/vram_model.sv
//////////////////////////////////////////////////
// Behavioural 64K x 16 SRAM.
// Byte-enabled writes on the clock, read data
// driven onto the shared data bus while selected.
//////////////////////////////////////////////////

`default_nettype none

module vram_model (
  input  logic        clk,
  input  logic        en_n,
  input  logic        rd_n,
  input  logic        wr_n,
  input  logic [1:0]  be_n,
  input  logic [15:0] addr,
  inout  wire  [15:0] data
);

  logic [15:0] mem [0:65535];

  // Power-up contents, a pattern of the whole address.
  initial begin
    for (int i = 0; i < 65536; i++) begin
      mem[i] = {i[7:0], i[15:8]} ^ 16'h5a3c;
    end
  end

  // Asynchronous read while chip and output enables are low.
  assign data = (!en_n && !rd_n) ? mem[addr] : 'z;

  // Write each enabled byte lane.
  always @(posedge clk) begin
    if (!en_n && !wr_n) begin
      if (!be_n[0]) mem[addr][7:0] <= data[7:0];
      if (!be_n[1]) mem[addr][15:8] <= data[15:8];
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_chrono_bus.sv
//////////////////////////////////////////////////
// Chrono bus testbench.
// Host bus tasks, shadow memory reference,
// a compare process and a watchdog.
//////////////////////////////////////////////////

`default_nettype none

module tb_chrono_bus;

  localparam int CLK_PERIOD   = 4;
  localparam int NUM_RANDOM   = 16;
  // Each access is ale, six strobe cycles and one idle cycle.
  localparam int NUM_ACCESSES = 2 * NUM_RANDOM + 40;
  localparam int TIMEOUT      = (NUM_ACCESSES * 10 + 100) * CLK_PERIOD;
  localparam logic [15:0] ID_VALUE = 16'h4343;

  logic        clk = 1'b0;
  logic        reset;
  logic        mpu_rd_n;
  logic        mpu_wr_n;
  logic        mpu_ale;
  logic [7:0]  mpu_ah;
  logic [7:0]  ad_out;
  logic        ad_en;
  wire  [7:0]  mpu_ad;
  wire         vram_en_n;
  wire         vram_rd_n;
  wire         vram_wr_n;
  wire  [1:0]  vram_be_n;
  wire  [15:0] vram_addr;
  wire  [15:0] vram_data;

  // Reference state.
  logic [15:0] shadow_mem [0:65535];
  logic [15:0] scratch_shadow;
  logic [1:0]  bank_shadow;
  logic [31:0] seed;

  // Pending checks, drained by the compare process.
  string       name_q[$];
  string       what_q[$];
  logic [15:0] exp_q[$];
  logic [15:0] act_q[$];
  string       cmp_name;
  string       cmp_what;
  logic [15:0] cmp_exp;
  logic [15:0] cmp_act;
  int          checks = 0;
  int          errors = 0;
  string       cur_test;
  int          checks_start;
  int          errors_start;

  // Host drives the muxed bus only through its own enable.
  assign mpu_ad = ad_en ? ad_out : 'z;

  chrono_bus_top dut0 (
    .clk(clk), .reset(reset),
    .mpu_rd_n(mpu_rd_n), .mpu_wr_n(mpu_wr_n), .mpu_ale(mpu_ale),
    .mpu_ah(mpu_ah), .mpu_ad(mpu_ad),
    .vram_en_n(vram_en_n), .vram_rd_n(vram_rd_n), .vram_wr_n(vram_wr_n),
    .vram_be_n(vram_be_n), .vram_addr(vram_addr), .vram_data(vram_data)
  );

  vram_model mem0 (
    .clk(clk), .en_n(vram_en_n), .rd_n(vram_rd_n), .wr_n(vram_wr_n),
    .be_n(vram_be_n), .addr(vram_addr), .data(vram_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // Reference model.
  //////////////////////////////////////////////////

  // Same power-up pattern as the SRAM model.
  function automatic logic [15:0] fill_word(input logic [15:0] a);
    return {a[7:0], a[15:8]} ^ 16'h5a3c;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Byte the host should see at a byte address.
  function automatic logic [7:0] expected_byte(input logic [15:0] addr);
    logic [15:0] word;
    if (addr[15]) begin
      word = shadow_mem[{bank_shadow, addr[14:1]}];
    end else begin
      case (addr[15:1])
        15'd0:   word = ID_VALUE;
        15'd1:   word = scratch_shadow;
        15'd2:   word = {14'd0, bank_shadow};
        default: word = 16'h0000;
      endcase
    end
    return addr[0] ? word[15:8] : word[7:0];
  endfunction

  // Odd address is the high byte; bank takes only its low byte.
  task automatic update_shadow(input logic [15:0] addr, input logic [7:0] data);
    logic [15:0] idx;
    idx = {bank_shadow, addr[14:1]};
    if (addr[15]) begin
      if (addr[0]) shadow_mem[idx][15:8] = data;
      else shadow_mem[idx][7:0] = data;
    end else if (addr[15:1] == 15'd1) begin
      if (addr[0]) scratch_shadow[15:8] = data;
      else scratch_shadow[7:0] = data;
    end else if (addr[15:1] == 15'd2 && !addr[0]) begin
      bank_shadow = data[1:0];
    end
  endtask

  //////////////////////////////////////////////////
  // Host bus tasks and check bookkeeping.
  //////////////////////////////////////////////////

  task automatic record_check(input string what, input logic [15:0] expected,
                              input logic [15:0] actual);
    name_q.push_back(cur_test);
    what_q.push_back(what);
    exp_q.push_back(expected);
    act_q.push_back(actual);
  endtask

  // One ale cycle with the address, then ale drops.
  task automatic address_phase(input logic [15:0] addr);
    @(negedge clk);
    mpu_ale = 1'b1;
    mpu_ah  = addr[15:8];
    ad_out  = addr[7:0];
    ad_en   = 1'b1;
    @(negedge clk);
    mpu_ale = 1'b0;
  endtask

  task automatic host_write(input logic [15:0] addr, input logic [7:0] data);
    address_phase(addr);
    ad_out   = data;
    mpu_wr_n = 1'b0;
    repeat (6) @(negedge clk);
    mpu_wr_n = 1'b1;
    ad_en    = 1'b0;
    update_shadow(addr, data);
  endtask

  // Data is sampled on the last falling edge of the strobe.
  task automatic host_read(input logic [15:0] addr);
    logic [7:0] got;
    address_phase(addr);
    ad_en    = 1'b0;
    mpu_rd_n = 1'b0;
    repeat (6) @(negedge clk);
    got      = mpu_ad;
    mpu_rd_n = 1'b1;
    record_check($sformatf("byte %h", addr), {8'h00, expected_byte(addr)}, {8'h00, got});
  endtask

  task automatic start_test(input string name);
    cur_test     = name;
    checks_start = checks;
    errors_start = errors;
  endtask

  // The compare process drains the queue on the rising edge before this.
  task automatic end_test;
    @(negedge clk);
    $display("Test %s finished: %0d checks, %0d errors", cur_test,
             checks - checks_start, errors - errors_start);
  endtask

  // Compare process.
  always @(posedge clk) begin
    while (exp_q.size() > 0) begin
      cmp_name = name_q.pop_front();
      cmp_what = what_q.pop_front();
      cmp_exp  = exp_q.pop_front();
      cmp_act  = act_q.pop_front();
      checks++;
      if (cmp_act !== cmp_exp) begin
        errors++;
        $display("Error %s: %s expected %h actual %h", cmp_name, cmp_what, cmp_exp, cmp_act);
      end
    end
  end

  // Watchdog.
  initial begin
    #(TIMEOUT);
    $display("Timeout: the tests did not finish within %0d time units", TIMEOUT);
    $display("** FAIL **");
    $finish;
  end

  //////////////////////////////////////////////////
  // Test sequence.
  //////////////////////////////////////////////////
  initial begin
    logic [15:0] rand_addr [NUM_RANDOM];
    logic [15:0] addr;
    logic [15:0] idx;
    reset          = 1'b1;
    mpu_rd_n       = 1'b1;
    mpu_wr_n       = 1'b1;
    mpu_ale        = 1'b0;
    mpu_ah         = 8'h00;
    ad_out         = 8'h00;
    ad_en          = 1'b0;
    seed           = 32'h631b_ad0e;
    scratch_shadow = 16'h0000;
    bank_shadow    = 2'b00;
    for (int i = 0; i < 65536; i++) begin
      shadow_mem[i] = fill_word(i[15:0]);
    end
    repeat (2) @(negedge clk);
    reset = 1'b0;

    // Controls idle high, ID readable in both bytes.
    start_test("reset_and_id");
    record_check("vram controls", 16'h001f,
                 {11'd0, vram_en_n, vram_rd_n, vram_wr_n, vram_be_n});
    host_read(16'h0000);
    host_read(16'h0001);
    end_test;

    start_test("scratch_bytes");
    host_write(16'h0003, 8'hc5);
    host_read(16'h0003);
    host_read(16'h0002);
    host_write(16'h0002, 8'h71);
    host_read(16'h0002);
    host_read(16'h0003);
    end_test;

    // Random bank, random window bytes, then read back.
    start_test("random_vram");
    seed = lcg_next(seed);
    host_write(16'h0004, seed[23:16]);
    host_read(16'h0004);
    for (int i = 0; i < NUM_RANDOM; i++) begin
      seed = lcg_next(seed);
      addr = {1'b1, seed[30:16]};
      rand_addr[i] = addr;
      host_write(addr, seed[15:8]);
      // SRAM word is the bank followed by the window offset.
      idx = {bank_shadow, addr[14:1]};
      record_check($sformatf("sram word %h", idx), shadow_mem[idx], mem0.mem[idx]);
    end
    for (int i = 0; i < NUM_RANDOM; i++) begin
      host_read(rand_addr[i]);
    end
    end_test;

    start_test("vram_byte_lanes");
    host_read(16'h8a42);
    host_read(16'h8a43);
    host_write(16'h8a43, 8'h3e);
    host_read(16'h8a43);
    host_read(16'h8a42);
    end_test;

    start_test("bank_switch");
    host_write(16'h0004, 8'h01);
    host_read(16'h8010);
    host_read(16'h8011);
    host_write(16'h0004, 8'h02);
    host_read(16'h8010);
    host_read(16'h8011);
    host_read(16'h0004);
    end_test;

    // Unmapped registers read zero and swallow writes.
    start_test("unmapped_regs");
    host_read(16'h0006);
    host_read(16'h0007);
    host_read(16'h0100);
    host_read(16'h7fff);
    host_write(16'h0006, 8'hff);
    host_write(16'h0101, 8'haa);
    host_read(16'h0006);
    host_read(16'h0101);
    host_read(16'h0000);
    host_read(16'h0002);
    host_read(16'h0003);
    host_read(16'h0004);
    end_test;

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
common/chrono_pkg.sv
avr_bus/avr_bus_adapter.sv
source/mpu_decode.sv
source/ctrl_registers.sv
vram/vram_controller.sv
source/read_return.sv
source/chrono_bus_top.sv
tests/vram_model.sv
tests/tb_chrono_bus.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and judge the result from the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f \
  --top-module tb_chrono_bus -o sim_chrono_bus

./obj_dir/sim_chrono_bus | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
